// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := rv_mem_bridge_tb
FILELIST   := rv_mem_bridge.f
OBJ_DIR    := obj_dir
COMMON     := --timing --timescale 1ns/1ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary --assert $(COMMON)
PASS_MSG   := Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/half_cmd_fifo.sv ====
// -----------------------------
// half_cmd_fifo: small synchronous
// queue of halfword commands
// -----------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_bridge_defs.svh"

module half_cmd_fifo #(
  parameter int DEPTH = `RVB_FIFO_DEPTH
) (
  input  wire                         clk,
  input  wire                         sys_resetn,
  input  wire                         i_push,
  input  wire  rv_mem_pkg::half_cmd_t i_cmd,
  input  wire                         i_pop,
  output rv_mem_pkg::half_cmd_t       o_cmd,
  output logic                        o_full,
  output logic                        o_empty
);

  import rv_mem_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  half_cmd_t        slots [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign o_full  = (count == FULL_CNT);
  assign o_empty = (count == '0);
  assign o_cmd   = slots[rd_ptr];   // head always visible

  // a full queue still takes a push when the head leaves that cycle
  assign do_push = i_push & (~o_full | i_pop);
  assign do_pop  = i_pop & ~o_empty;

  always_ff @(posedge clk) begin
    if (do_push)
      slots[wr_ptr] <= i_cmd;
  end

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;

      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;       // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/halfword_ram.sv ====
// -----------------------------
// halfword_ram: byte-lane halfword
// memory, one command per cycle,
// registered response
// -----------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_bridge_defs.svh"

module halfword_ram (
  input  wire                         clk,
  input  wire                         sys_resetn,
  input  wire                         i_empty,
  input  wire  rv_mem_pkg::half_cmd_t i_cmd,
  output logic                        o_pop,
  output logic                        o_rsp_valid,
  output rv_mem_pkg::half_rsp_t       o_rsp
);

  import rv_mem_pkg::*;

  localparam int WORDS = 1 << `RVB_MEM_DEPTH_LOG2;

  logic [`RVB_HALF_W-1:0]        mem [WORDS];
  logic [`RVB_MEM_DEPTH_LOG2-1:0] idx;
  logic [`RVB_HALF_W-1:0]        cur;
  logic [`RVB_HALF_W-1:0]        merged;
  logic                          is_wr;

  // always ready, so take the head whenever there is one
  assign o_pop = ~i_empty;

  assign idx   = i_cmd.haddr[`RVB_MEM_DEPTH_LOG2-1:0];   // upper haddr bits alias
  assign cur   = mem[idx];
  assign is_wr = (i_cmd.op == OP_WRITE);

  // per-lane merge of write data into the stored halfword
  assign merged = {i_cmd.ds[1] ? i_cmd.wdata[15:8] : cur[15:8],
                   i_cmd.ds[0] ? i_cmd.wdata[7:0]  : cur[7:0]};

  always_ff @(posedge clk) begin
    if (o_pop && is_wr)
      mem[idx] <= merged;
  end

  // response data: read value, or the word as it stands after a write
  always_ff @(posedge clk) begin
    if (o_pop) begin
      o_rsp.rdata <= is_wr ? merged : cur;
      o_rsp.hi    <= i_cmd.haddr[0];
    end
  end

  always_ff @(posedge clk) begin
    if (!sys_resetn)
      o_rsp_valid <= 1'b0;
    else
      o_rsp_valid <= o_pop;    // one cycle after every pop
  end

endmodule

`default_nettype wire

// ==== design/rv_half_sequencer.sv ====
// -----------------------------
// splits core requests into
// halfword commands and
// reassembles read data
// -----------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_bridge_defs.svh"

module rv_half_sequencer (
  input  wire                       clk,
  input  wire                       sys_resetn,
  input  wire                       i_valid,
  input  wire  [`RVB_ADDR_W-1:0]    i_addr,
  input  wire  [`RVB_DATA_W-1:0]    i_wdata,
  input  wire  [3:0]                i_wstrb,
  input  wire                       i_full,
  input  wire                       i_rsp_valid,
  input  wire  rv_mem_pkg::half_rsp_t i_rsp,
  output logic                      o_push,
  output rv_mem_pkg::half_cmd_t     o_cmd,
  output logic                      o_ready,
  output logic [`RVB_DATA_W-1:0]    o_rdata
);

  import rv_mem_pkg::*;

  seq_state_e             state;
  logic                   valid_r;    // i_valid one cycle late
  logic                   pending;    // edge seen while busy
  logic [1:0]             rsp_left;   // responses still owed
  logic                   rd_r;
  logic [`RVB_HALF_W-1:0] lo_half;    // lower read half until the upper arrives

  logic      new_req;
  logic      start;
  logic      push_hi;
  logic      last_rsp;
  logic      is_wr;
  logic      hi_only;
  logic      lo_only;
  half_cmd_t cmd_lo;
  half_cmd_t cmd_hi;

  assign new_req  = i_valid & ~valid_r;
  assign start    = (state == SEQ_IDLE) & (new_req | pending);
  assign push_hi  = (state == SEQ_ISSUE_HI) & ~i_full;
  assign last_rsp = i_rsp_valid & (rsp_left == 2'd1);

  // zero strobe means read
  assign is_wr   = |i_wstrb;
  assign hi_only = is_wr & (i_wstrb[1:0] == 2'b00);
  assign lo_only = is_wr & (i_wstrb[3:2] == 2'b00);

  // core holds address and data until o_ready
  always_comb begin
    cmd_lo.op    = is_wr ? OP_WRITE : OP_READ;
    cmd_lo.haddr = {i_addr[`RVB_ADDR_W-1:2], 1'b0};
    cmd_lo.ds    = is_wr ? i_wstrb[1:0] : 2'b11;
    cmd_lo.wdata = i_wdata[15:0];

    cmd_hi.op    = is_wr ? OP_WRITE : OP_READ;
    cmd_hi.haddr = {i_addr[`RVB_ADDR_W-1:2], 1'b1};
    cmd_hi.ds    = is_wr ? i_wstrb[3:2] : 2'b11;
    cmd_hi.wdata = i_wdata[31:16];
  end

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      state    <= SEQ_IDLE;
      valid_r  <= 1'b0;
      pending  <= 1'b0;
      rsp_left <= 2'd0;
      o_push   <= 1'b0;
      o_ready  <= 1'b0;
    end else begin
      valid_r <= i_valid;
      o_push  <= 1'b0;
      o_ready <= 1'b0;

      if (start)
        pending <= 1'b0;
      else if (new_req)
        pending <= 1'b1;     // served after the current request

      if (i_rsp_valid)
        rsp_left <= rsp_left - 2'd1;

      case (state)
        SEQ_IDLE: begin
          if (start) begin
            o_push   <= 1'b1;
            rsp_left <= (hi_only | lo_only) ? 2'd1 : 2'd2;
            state    <= (hi_only | lo_only) ? SEQ_WAIT : SEQ_ISSUE_HI;
          end
        end
        SEQ_ISSUE_HI: begin
          if (push_hi) begin
            o_push <= 1'b1;
            state  <= SEQ_WAIT;
          end
        end
        SEQ_WAIT: begin
          if (last_rsp) begin
            o_ready <= 1'b1;
            state   <= SEQ_IDLE;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // command payload and read assembly
  always_ff @(posedge clk) begin
    if (start) begin
      o_cmd <= hi_only ? cmd_hi : cmd_lo;
      rd_r  <= ~is_wr;
    end else if (push_hi) begin
      o_cmd <= cmd_hi;
    end

    if (i_rsp_valid && !i_rsp.hi)
      lo_half <= i_rsp.rdata;

    // reads end on the upper half; writes leave o_rdata alone
    if (last_rsp && rd_r)
      o_rdata <= {i_rsp.rdata, lo_half};
  end

endmodule

`default_nettype wire

// ==== design/rv_mem_bridge.sv ====
// -----------------------------
// rv_mem_bridge: top level, core
// bus to halfword memory through
// sequencer, queue and ram
// -----------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_bridge_defs.svh"

module rv_mem_bridge (
  input  wire                    clk,
  input  wire                    sys_resetn,
  input  wire                    i_valid,
  input  wire  [`RVB_ADDR_W-1:0] i_addr,
  input  wire  [`RVB_DATA_W-1:0] i_wdata,
  input  wire  [3:0]             i_wstrb,
  output logic                   o_ready,
  output logic [`RVB_DATA_W-1:0] o_rdata
);

  import rv_mem_pkg::*;

  half_cmd_t push_cmd;    // sequencer into queue
  half_cmd_t head_cmd;    // queue head into ram
  half_rsp_t rsp;
  logic      push;
  logic      pop;
  logic      full;
  logic      empty;
  logic      rsp_valid;

  rv_half_sequencer seq_inst (
    .clk         (clk),
    .sys_resetn  (sys_resetn),
    .i_valid     (i_valid),
    .i_addr      (i_addr),
    .i_wdata     (i_wdata),
    .i_wstrb     (i_wstrb),
    .i_full      (full),
    .i_rsp_valid (rsp_valid),
    .i_rsp       (rsp),
    .o_push      (push),
    .o_cmd       (push_cmd),
    .o_ready     (o_ready),
    .o_rdata     (o_rdata)
  );

  half_cmd_fifo #(
    .DEPTH (`RVB_FIFO_DEPTH)
  ) fifo_inst (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .i_push     (push),
    .i_cmd      (push_cmd),
    .i_pop      (pop),
    .o_cmd      (head_cmd),
    .o_full     (full),
    .o_empty    (empty)
  );

  halfword_ram ram_inst (
    .clk         (clk),
    .sys_resetn  (sys_resetn),
    .i_empty     (empty),
    .i_cmd       (head_cmd),
    .o_pop       (pop),
    .o_rsp_valid (rsp_valid),
    .o_rsp       (rsp)
  );

endmodule

`default_nettype wire

// ==== design/rv_mem_bridge_defs.svh ====
// -----------------------------
// widths and sizes shared by the
// 32-bit to 16-bit memory bridge
// -----------------------------

`ifndef RV_MEM_BRIDGE_DEFS_SVH
`define RV_MEM_BRIDGE_DEFS_SVH

// core side
`define RVB_ADDR_W 23         // byte address
`define RVB_DATA_W 32

// memory side
`define RVB_HALF_W 16
`define RVB_HADDR_W 22        // word address plus half select

// on-chip halfword memory, 1k halfwords
`define RVB_MEM_DEPTH_LOG2 10

// halfword command queue
`define RVB_FIFO_DEPTH 4

`endif

// ==== design/rv_mem_pkg.sv ====
// -----------------------------
// bridge types: opcode and state
// enums, halfword command and
// response structs
// -----------------------------
`default_nettype none

`include "rv_mem_bridge_defs.svh"

package rv_mem_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  // request sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE     = 2'd0,
    SEQ_ISSUE_HI = 2'd1,  // second half still to push
    SEQ_WAIT     = 2'd2   // all pushed, collecting responses
  } seq_state_e;

  // one halfword operation, 41 bits
  typedef struct packed {
    mem_op_e                 op;
    logic [`RVB_HADDR_W-1:0] haddr;  // bit 0 selects upper half
    logic [1:0]              ds;     // byte lanes, bit 1 = [15:8]
    logic [`RVB_HALF_W-1:0]  wdata;
  } half_cmd_t;

  // one halfword response, 17 bits
  typedef struct packed {
    logic                   hi;
    logic [`RVB_HALF_W-1:0] rdata;
  } half_rsp_t;

endpackage

`default_nettype wire

// ==== rv_mem_bridge.f ====
+incdir+design
design/rv_mem_pkg.sv
design/half_cmd_fifo.sv
design/halfword_ram.sv
design/rv_half_sequencer.sv
design/rv_mem_bridge.sv
verif/rv_mem_bridge_tb.sv

// ==== verif/rv_mem_bridge_tb.sv ====
// ------------------------------
// testbench for the memory bridge
// request table, random mix,
// shadow memory model, watchdog
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rv_mem_bridge_defs.svh"

module rv_mem_bridge_tb;

  localparam int N_TABLE   = 17;
  localparam int N_RAND    = 40;
  localparam int WD_CYCLES = (N_TABLE + N_RAND) * 20;

  // one core request, hold keeps i_valid up for a while after o_ready
  typedef struct packed {
    logic [`RVB_ADDR_W-1:0] addr;
    logic [`RVB_DATA_W-1:0] wdata;
    logic [3:0]             wstrb;
    logic                   hold;
  } req_t;

  logic                   clk;
  logic                   sys_resetn;
  logic                   i_valid;
  logic [`RVB_ADDR_W-1:0] i_addr;
  logic [`RVB_DATA_W-1:0] i_wdata;
  logic [3:0]             i_wstrb;
  logic                   o_ready;
  logic [`RVB_DATA_W-1:0] o_rdata;

  req_t        tab [N_TABLE];
  logic [7:0]  shadow [2048];    // byte addressed, 512 words
  logic [3:0]  lanes_set [512];  // written lanes per word
  logic [31:0] last_rd;
  logic        have_rd;
  int unsigned cycle = 0;
  int          data_errs = 0;
  int          ctrl_errs = 0;
  integer      seed = 32'h94a3_4568;

  rv_mem_bridge rv_mem_bridge_inst (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .i_valid    (i_valid),
    .i_addr     (i_addr),
    .i_wdata    (i_wdata),
    .i_wstrb    (i_wstrb),
    .o_ready    (o_ready),
    .o_rdata    (o_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  function automatic req_t mk_req(input logic [`RVB_ADDR_W-1:0] a,
                                  input logic [`RVB_DATA_W-1:0] d,
                                  input logic [3:0] s, input logic h);
    req_t r;
    r.addr  = a;
    r.wdata = d;
    r.wstrb = s;
    r.hold  = h;
    return r;
  endfunction

  function automatic logic [31:0] shadow_word(input logic [`RVB_ADDR_W-1:0] a);
    return {shadow[{a[10:2], 2'd3}], shadow[{a[10:2], 2'd2}],
            shadow[{a[10:2], 2'd1}], shadow[{a[10:2], 2'd0}]};
  endfunction

  task automatic write_shadow(input req_t r);
    for (int l = 0; l < 4; l++) begin
      if (r.wstrb[l]) begin
        shadow[{r.addr[10:2], 2'(l)}] = r.wdata[8*l +: 8];
        lanes_set[r.addr[10:2]][l]   = 1'b1;
      end
    end
  endtask

  task automatic report_counts();
    $display("errors: %0d data mismatches, %0d handshake mismatches",
             data_errs, ctrl_errs);
  endtask

  // entered 1 ns after a rising edge, leaves at the same phase
  task automatic run_req(input req_t r);
    int unsigned req_cycle;
    int unsigned lat;
    int unsigned exp_lat;
    logic [31:0] exp_data;
    logic        is_wr;
    is_wr   = (r.wstrb != 4'h0);
    // one-half writes skip a memory slot
    exp_lat = (is_wr && (r.wstrb[1:0] == 2'b00 || r.wstrb[3:2] == 2'b00)) ? 3 : 4;
    i_addr    = r.addr;
    i_wdata   = r.wdata;
    i_wstrb   = r.wstrb;
    i_valid   = 1'b1;
    req_cycle = cycle + 1;           // edge that samples the request
    do begin
      @(posedge clk);
      #1;
    end while (o_ready !== 1'b1);
    lat = cycle - req_cycle;
    assert (lat == exp_lat) else begin
      ctrl_errs++;
      $display("mismatch at %0t: addr 0x%06h o_ready after %0d cycles, expected %0d",
               $time, r.addr, lat, exp_lat);
    end
    if (is_wr) begin
      write_shadow(r);
      // read data holds across writes
      assert (!have_rd || o_rdata === last_rd) else begin
        data_errs++;
        $display("mismatch at %0t: o_rdata 0x%08h changed on write, expected 0x%08h",
                 $time, o_rdata, last_rd);
      end
    end else begin
      exp_data = shadow_word(r.addr);
      assert (o_rdata === exp_data) else begin
        data_errs++;
        $display("mismatch at %0t: read addr 0x%06h got 0x%08h expected 0x%08h",
                 $time, r.addr, o_rdata, exp_data);
      end
      last_rd = exp_data;
      have_rd = 1'b1;
    end
    if (r.hold) begin
      repeat (3) begin             // held valid is no new request
        @(posedge clk);
        #1;
        assert (o_ready === 1'b0) else begin
          ctrl_errs++;
          $display("mismatch at %0t: o_ready repeated while i_valid held", $time);
        end
      end
    end
    i_valid = 1'b0;
    @(posedge clk);
    #1;
    assert (o_ready === 1'b0) else begin
      ctrl_errs++;
      $display("mismatch at %0t: o_ready longer than one cycle", $time);
    end
  endtask

  task automatic run_random(input int n);
    req_t       r;
    logic [5:0] word;
    logic       do_rd;
    for (int k = 0; k < n; k++) begin
      word    = 6'($random(seed));   // 64 words from address 0
      r.addr  = '0;
      r.addr[7:2] = word;
      r.wdata = $random(seed);
      r.wstrb = 4'($random(seed));
      do_rd   = 1'($random(seed));
      r.hold  = 1'($random(seed));
      if (do_rd && lanes_set[r.addr[10:2]] == 4'hf)
        r.wstrb = 4'h0;
      else if (do_rd || r.wstrb == 4'h0)
        r.wstrb = 4'hf;              // word not complete yet, fill it
      run_req(r);
    end
  endtask

  initial begin
    tab[0]  = mk_req(23'h000, 32'h1234_5678, 4'hf, 1'b0);
    tab[1]  = mk_req(23'h000, 32'h0000_0000, 4'h0, 1'b1);
    tab[2]  = mk_req(23'h004, 32'hdead_beef, 4'hf, 1'b0);
    tab[3]  = mk_req(23'h004, 32'h0000_a5c3, 4'h3, 1'b0);  // lower half
    tab[4]  = mk_req(23'h004, 32'h7e81_0000, 4'hc, 1'b1);  // upper half
    tab[5]  = mk_req(23'h004, 32'h0000_0000, 4'h0, 1'b0);
    tab[6]  = mk_req(23'h008, 32'h3c3c_3c3c, 4'hf, 1'b0);
    tab[7]  = mk_req(23'h008, 32'h0000_0011, 4'h1, 1'b0);  // single bytes
    tab[8]  = mk_req(23'h008, 32'h0000_2200, 4'h2, 1'b0);
    tab[9]  = mk_req(23'h008, 32'h0033_0000, 4'h4, 1'b0);
    tab[10] = mk_req(23'h008, 32'h4400_0000, 4'h8, 1'b0);
    tab[11] = mk_req(23'h008, 32'h0000_0000, 4'h0, 1'b0);
    tab[12] = mk_req(23'h7fc, 32'hcafe_f00d, 4'hf, 1'b0);  // last word
    tab[13] = mk_req(23'h7fc, 32'h0000_0000, 4'h0, 1'b0);
    tab[14] = mk_req(23'h000, 32'h0000_0000, 4'h0, 1'b0);
    tab[15] = mk_req(23'h008, 32'h00aa_bb00, 4'h6, 1'b0);  // middle lanes
    tab[16] = mk_req(23'h008, 32'h0000_0000, 4'h0, 1'b0);
    foreach (lanes_set[w])
      lanes_set[w] = 4'h0;
    have_rd    = 1'b0;
    last_rd    = '0;
    sys_resetn = 1'b0;
    i_valid    = 1'b0;
    i_addr     = '0;
    i_wdata    = '0;
    i_wstrb    = '0;
    repeat (5) @(posedge clk);
    #1 sys_resetn = 1'b1;
    repeat (3) begin
      @(posedge clk);
      #1;
      assert (o_ready === 1'b0) else begin
        ctrl_errs++;
        $display("mismatch at %0t: o_ready high with no request", $time);
      end
    end
    for (int t = 0; t < N_TABLE; t++)
      run_req(tab[t]);
    run_random(N_RAND);
    report_counts();
    if (data_errs == 0 && ctrl_errs == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  // hang guard, 20 cycles per request
  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("timeout: bridge did not finish the requests within %0d cycles", WD_CYCLES);
    report_counts();
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
